/* filelist.f */
hdl/reference_pkg.sv
hdl/ref_stream_if.sv
hdl/angle_emulator.sv
hdl/reference_controller.sv
hdl/quadrature_generator.sv
hdl/inverse_park_scaler.sv
hdl/reference_serializer.sv
hdl/multiphase_reference_top.sv
testbench/multiphase_reference_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f filelist.f \
    --top-module multiphase_reference_tb -o multiphase_reference_sim

output=$(./obj_dir/multiphase_reference_sim)
echo "$output"

# The run passes only if the testbench printed its pass line
echo "$output" | grep -qx "Finished with no errors"

/* testbench/multiphase_reference_tb.sv */
`timescale 1ns/1ps

module multiphase_reference_tb;
    import reference_pkg::*;

    localparam real pi = 3.14159265358979;
    localparam int reference_rounds = 4;
    localparam int emulation_rounds = 3;
    localparam int emulation_period = 3;
    // Setup and register traffic plus each round with its drain and burst, doubled for margin
    localparam int timeout_cycles = 2 * (250 + (reference_rounds + emulation_rounds) * 250);

    logic clock;
    logic reset;
    logic sync;
    logic signed [data_width-1:0] id_setpoint;
    logic signed [data_width-1:0] iq_setpoint;
    logic [n_phases*angle_width-1:0] phase_shifts;
    logic [angle_width-1:0] phase_data;
    logic phase_valid;
    logic phase_ready;
    logic [axil_addr_width-1:0] awaddr;
    logic [axil_addr_width-1:0] araddr;
    logic [axil_data_width-1:0] wdata;
    logic [axil_data_width-1:0] rdata;
    logic awvalid;
    logic awready;
    logic wvalid;
    logic wready;
    logic bvalid;
    logic bready;
    logic arvalid;
    logic arready;
    logic rvalid;
    logic rready;
    logic [angle_width-1:0] angle_out_data;
    logic angle_out_valid;
    logic angle_emulation;
    logic [data_width-1:0] ref_data;
    logic [dest_width-1:0] ref_dest;
    logic ref_valid;

    int errors = 0;
    int property_errors = 0;
    int test_start_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycle_count = 0;
    integer seed = 32'hfb6;

    multiphase_reference_top UUT (.*);

    initial clock = 1'b0;
    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: the tests did not complete within %0d cycles", timeout_cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    assert property (@(posedge clock) disable iff (!reset) angle_emulation |-> phase_ready)
        else begin
            $display("phase_ready dropped in emulation mode at %0t ns", $time);
            property_errors++;
        end

    assert property (@(posedge clock) disable iff (!reset) awvalid && awready |=> bvalid)
        else begin
            $display("no write response one cycle after a write at %0t ns", $time);
            property_errors++;
        end

    assert property (@(posedge clock) disable iff (!reset) arvalid && arready |=> rvalid)
        else begin
            $display("no read data one cycle after a read address at %0t ns", $time);
            property_errors++;
        end

    task automatic check_value(input string name, input logic [31:0] actual,
            input logic [31:0] expected);
        assert (actual === expected) else begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            errors++;
        end
    endtask

    task automatic check_true(input bit condition, input string message);
        assert (condition) else begin
            $display("%s at %0t ns", message, $time);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        int found;
        found = errors + property_errors - test_start_errors;
        tests_run++;
        if (found != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s with %0d errors", tests_run, name,
            found == 0 ? "passed" : "failed", found);
        test_start_errors = errors + property_errors;
    endtask

    // Full-wave table entry, round(32767 * sin(2*pi*k/256))
    function automatic int sine_entry(input int k);
        return int'(32767.0 * $sin(2.0 * pi * real'(k % 256) / 256.0));
    endfunction

    function automatic logic [data_width-1:0] expected_ref(input logic [angle_width-1:0] angle,
            input int phase, input logic signed [data_width-1:0] id,
            input logic signed [data_width-1:0] iq);
        logic [angle_width-1:0] shifted;
        int index;
        longint id_part;
        longint iq_part;
        shifted = angle + phase_shifts[phase*angle_width +: angle_width];
        index = int'(shifted[angle_width-1 -: 8]);
        // Both products are scaled back by 2^15 with floor rounding
        id_part = (longint'(id) * sine_entry(index)) >>> 15;
        iq_part = (-(longint'(iq) * sine_entry(index + 64))) >>> 15;
        return data_width'(id_part + iq_part);
    endfunction

    // True when delta equals the step added a tick count within the given range
    function automatic bit is_step_multiple(input logic [15:0] step, input logic [15:0] delta,
            input int min_ticks, input int max_ticks);
        for (int k = min_ticks; k <= max_ticks; k++) begin
            if (16'(k * step) == delta) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic axi_write(input logic [3:0] offset, input logic [31:0] value);
        @(negedge clock);
        awaddr = 32'(offset);
        wdata = value;
        awvalid = 1'b1;
        wvalid = 1'b1;
        #1;
        while (!(awready && wready)) begin
            @(negedge clock);
            #1;
        end
        @(negedge clock);
        awvalid = 1'b0;
        wvalid = 1'b0;
        check_value("bvalid", 32'(bvalid), 32'd1);
        bready = 1'b1;
        @(negedge clock);
        bready = 1'b0;
    endtask

    task automatic check_register(input logic [3:0] offset, input string name,
            input logic [31:0] expected);
        @(negedge clock);
        araddr = 32'(offset);
        arvalid = 1'b1;
        #1;
        while (!arready) begin
            @(negedge clock);
            #1;
        end
        @(negedge clock);
        arvalid = 1'b0;
        check_value("rvalid", 32'(rvalid), 32'd1);
        check_value(name, rdata, expected);
        rready = 1'b1;
        @(negedge clock);
        rready = 1'b0;
    endtask

    task automatic send_angle(input logic [angle_width-1:0] angle);
        @(negedge clock);
        phase_data = angle;
        phase_valid = 1'b1;
        #1;
        while (!phase_ready) begin
            @(negedge clock);
            #1;
        end
        @(negedge clock);
        phase_valid = 1'b0;
    endtask

    // The generator and scaler need one pass over the phases plus two register stages
    task automatic drain_pipeline();
        @(negedge clock);
        while (!phase_ready) begin
            @(negedge clock);
        end
        repeat (n_phases + 3) @(negedge clock);
    endtask

    task automatic check_burst(input logic [angle_width-1:0] angle,
            input logic signed [data_width-1:0] id, input logic signed [data_width-1:0] iq);
        int latency;
        @(negedge clock);
        sync = 1'b1;
        @(negedge clock);
        sync = 1'b0;
        latency = 1;
        while (!ref_valid && latency < 8) begin
            @(negedge clock);
            latency++;
        end
        check_true(latency == 3, "the reference burst did not start 3 cycles after sync");
        for (int i = 0; i < n_phases; i++) begin
            check_value("ref_valid", 32'(ref_valid), 32'd1);
            check_value("ref_dest", 32'(ref_dest), 32'(i));
            check_value("ref_data", 32'(ref_data), 32'(expected_ref(angle, i, id, iq)));
            @(negedge clock);
        end
        check_value("ref_valid", 32'(ref_valid), 32'd0);
    endtask

    initial begin
        logic [31:0] word;
        logic [15:0] step;
        logic [angle_width-1:0] angle;
        logic [angle_width-1:0] next_angle;
        logic [angle_width-1:0] previous_angle;
        int trigger_cycle;
        int previous_cycle;
        int elapsed;
        reset = 1'b0;
        sync = 1'b0;
        id_setpoint = '0;
        iq_setpoint = '0;
        phase_data = '0;
        phase_valid = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        previous_angle = '0;
        previous_cycle = 0;
        // Six phases spaced 60 degrees apart, phase 0 in the low bits
        phase_shifts = {16'hd555, 16'haaab, 16'h8000, 16'h5555, 16'h2aab, 16'h0000};
        repeat (4) @(negedge clock);
        reset = 1'b1;

        @(negedge clock);
        check_value("ref_valid", 32'(ref_valid), 32'd0);
        check_value("angle_out_valid", 32'(angle_out_valid), 32'd0);
        check_value("bvalid", 32'(bvalid), 32'd0);
        check_value("rvalid", 32'(rvalid), 32'd0);
        check_value("phase_ready", 32'(phase_ready), 32'd1);
        check_register(reg_offset_mode, "mode", 32'd0);
        check_register(reg_offset_advance, "advance", 32'd0);
        check_register(reg_offset_period, "period", 32'd0);
        finish_test("reset state");

        // Advance is still zero here, so the accumulator stays at zero
        axi_write(reg_offset_mode, 32'h5);
        check_register(reg_offset_mode, "mode", 32'h1);
        check_value("angle_emulation", 32'(angle_emulation), 32'd1);
        axi_write(reg_offset_mode, 32'h2);
        check_register(reg_offset_mode, "mode", 32'h0);
        check_value("angle_emulation", 32'(angle_emulation), 32'd0);
        word = $random(seed);
        axi_write(reg_offset_advance, word);
        check_register(reg_offset_advance, "advance", word);
        word = $random(seed);
        axi_write(reg_offset_period, word);
        check_register(reg_offset_period, "period", word);
        finish_test("register bank");

        angle = 16'($random(seed));
        next_angle = 16'($random(seed));
        @(negedge clock);
        phase_data = angle;
        phase_valid = 1'b1;
        #1;
        check_value("phase_ready", 32'(phase_ready), 32'd1);
        check_value("angle_out_valid", 32'(angle_out_valid), 32'd1);
        check_value("angle_out_data", 32'(angle_out_data), 32'(angle));
        @(negedge clock);
        phase_data = next_angle;
        for (int i = 0; i < n_phases; i++) begin
            #1;
            check_value("phase_ready", 32'(phase_ready), 32'd0);
            @(negedge clock);
        end
        #1;
        check_value("phase_ready", 32'(phase_ready), 32'd1);
        @(negedge clock);
        phase_valid = 1'b0;
        #1;
        check_true(!phase_ready, "the held angle was not accepted after the busy period");
        drain_pipeline();
        finish_test("external angle and back-pressure");

        for (int r = 0; r < reference_rounds; r++) begin
            angle = 16'($random(seed));
            id_setpoint = 16'($random(seed));
            iq_setpoint = 16'($random(seed));
            send_angle(angle);
            drain_pipeline();
            check_burst(angle, id_setpoint, iq_setpoint);
        end
        finish_test("references");

        word = $random(seed) | 32'h1;
        step = word[15:0];
        axi_write(reg_offset_advance, word);
        axi_write(reg_offset_period, 32'(emulation_period));
        axi_write(reg_offset_mode, 32'd1);
        check_value("angle_emulation", 32'(angle_emulation), 32'd1);
        for (int r = 0; r < emulation_rounds; r++) begin
            repeat (4 + ($unsigned($random(seed)) % 16)) @(negedge clock);
            id_setpoint = 16'($random(seed));
            iq_setpoint = 16'($random(seed));
            phase_valid = 1'b1;
            @(negedge clock);
            phase_valid = 1'b0;
            trigger_cycle = cycle_count;
            check_value("angle_out_valid", 32'(angle_out_valid), 32'd1);
            angle = angle_out_data;
            if (r > 0) begin
                // A window of this many cycles holds the floor or the ceiling of its tick count
                elapsed = trigger_cycle - previous_cycle;
                check_true(is_step_multiple(step, angle - previous_angle,
                    elapsed / (emulation_period + 1),
                    (elapsed + emulation_period) / (emulation_period + 1)),
                    "the emulated angle did not move by advance once per sampling period");
            end
            previous_angle = angle;
            previous_cycle = trigger_cycle;
            drain_pipeline();
            check_burst(angle, id_setpoint, iq_setpoint);
        end
        finish_test("emulation mode");

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
            errors + property_errors);
        if (errors + property_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* hdl/multiphase_reference_top.sv */
`timescale 1ns/1ps

module multiphase_reference_top (
    input  logic clock,
    input  logic reset,
    input  logic sync,
    input  logic signed [reference_pkg::data_width-1:0] id_setpoint,
    input  logic signed [reference_pkg::data_width-1:0] iq_setpoint,
    input  logic [reference_pkg::n_phases*reference_pkg::angle_width-1:0] phase_shifts,
    input  logic [reference_pkg::angle_width-1:0] phase_data,
    input  logic phase_valid,
    output logic phase_ready,
    input  logic [reference_pkg::axil_addr_width-1:0] awaddr,
    input  logic awvalid,
    output logic awready,
    input  logic [reference_pkg::axil_data_width-1:0] wdata,
    input  logic wvalid,
    output logic wready,
    output logic bvalid,
    input  logic bready,
    input  logic [reference_pkg::axil_addr_width-1:0] araddr,
    input  logic arvalid,
    output logic arready,
    output logic [reference_pkg::axil_data_width-1:0] rdata,
    output logic rvalid,
    input  logic rready,
    output logic [reference_pkg::angle_width-1:0] angle_out_data,
    output logic angle_out_valid,
    output logic angle_emulation,
    output logic [reference_pkg::data_width-1:0] ref_data,
    output logic [reference_pkg::dest_width-1:0] ref_dest,
    output logic ref_valid
);
    import reference_pkg::*;

    logic angle_accept;

    ref_stream_if #(.payload_t(logic [angle_width-1:0])) angle_stream ();
    ref_stream_if #(.payload_t(quad_pair_t)) pair_stream ();
    ref_stream_if #(.payload_t(logic signed [data_width-1:0])) ref_stream ();

    // The scaler latches its setpoints on every angle handshake
    assign angle_accept = angle_stream.valid && angle_stream.ready;

    reference_controller controller (
        .clock(clock),
        .reset(reset),
        .awaddr(awaddr),
        .awvalid(awvalid),
        .awready(awready),
        .wdata(wdata),
        .wvalid(wvalid),
        .wready(wready),
        .bvalid(bvalid),
        .bready(bready),
        .araddr(araddr),
        .arvalid(arvalid),
        .arready(arready),
        .rdata(rdata),
        .rvalid(rvalid),
        .rready(rready),
        .phase_data(phase_data),
        .phase_valid(phase_valid),
        .phase_ready(phase_ready),
        .angle_emulation(angle_emulation),
        .angle_out_data(angle_out_data),
        .angle_out_valid(angle_out_valid),
        .angle_stream(angle_stream)
    );

    quadrature_generator generator (
        .clock(clock),
        .reset(reset),
        .phase_shifts(phase_shifts),
        .angle_in(angle_stream),
        .pair_out(pair_stream)
    );

    inverse_park_scaler scaler (
        .clock(clock),
        .reset(reset),
        .id_setpoint(id_setpoint),
        .iq_setpoint(iq_setpoint),
        .angle_accept(angle_accept),
        .pair_in(pair_stream),
        .ref_out(ref_stream)
    );

    reference_serializer serializer (
        .clock(clock),
        .reset(reset),
        .sync(sync),
        .ref_in(ref_stream),
        .ref_data(ref_data),
        .ref_dest(ref_dest),
        .ref_valid(ref_valid)
    );

endmodule

/* hdl/reference_serializer.sv */
`timescale 1ns/1ps

module reference_serializer (
    input  logic clock,
    input  logic reset,
    input  logic sync,
    ref_stream_if.sink ref_in,
    output logic [reference_pkg::data_width-1:0] ref_data,
    output logic [reference_pkg::dest_width-1:0] ref_dest,
    output logic ref_valid
);
    import reference_pkg::*;

    logic [data_width-1:0] stored [n_phases];
    logic [1:0] sync_delay;
    logic [dest_width-1:0] burst_index;
    logic [dest_width-1:0] read_index;
    logic burst_start;

    assign ref_in.ready = 1'b1;

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < n_phases; i++) begin
                stored[i] <= '0;
            end
        end else if (ref_in.valid) begin
            stored[ref_in.dest] <= ref_in.data;
        end
    end

    // Two sync stages put the first burst beat three cycles after sync
    assign burst_start = sync_delay[1];
    assign read_index = burst_start ? '0 : burst_index;

    always_ff @(posedge clock) begin
        if (!reset) begin
            sync_delay <= '0;
            burst_index <= '0;
            ref_dest <= '0;
            ref_valid <= 1'b0;
        end else begin
            sync_delay <= {sync_delay[0], sync};
            ref_dest <= read_index;
            if (burst_start || burst_index != '0) begin
                ref_valid <= 1'b1;
                if (read_index == dest_width'(n_phases - 1)) begin
                    burst_index <= '0;
                end else begin
                    burst_index <= read_index + 1'b1;
                end
            end else begin
                ref_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        ref_data <= stored[read_index];
    end

    assert property (@(posedge clock) disable iff (!reset)
        ref_valid |-> ref_dest < dest_width'(n_phases));

endmodule

/* hdl/inverse_park_scaler.sv */
`timescale 1ns/1ps

module inverse_park_scaler (
    input logic clock,
    input logic reset,
    input logic signed [reference_pkg::data_width-1:0] id_setpoint,
    input logic signed [reference_pkg::data_width-1:0] iq_setpoint,
    input logic angle_accept,
    ref_stream_if.sink pair_in,
    ref_stream_if.source ref_out
);
    import reference_pkg::*;

    logic signed [data_width-1:0] id_latched;
    logic signed [data_width-1:0] iq_latched;
    logic signed [2*data_width-1:0] id_product;
    logic signed [2*data_width-1:0] iq_product;
    logic signed [data_width-1:0] id_term;
    logic signed [data_width-1:0] iq_term;
    quad_pair_t pair;

    // Setpoints are frozen per angle so all phases of one angle share them
    always_ff @(posedge clock) begin
        if (angle_accept) begin
            id_latched <= id_setpoint;
            iq_latched <= iq_setpoint;
        end
    end

    assign pair = pair_in.data;

    // The Iq product is negated before scaling, which matters for the rounding
    assign id_product = id_latched * $signed(pair.sine);
    assign iq_product = -(iq_latched * $signed(pair.cosine));
    assign id_term = data_width'(id_product >>> (data_width - 1));
    assign iq_term = data_width'(iq_product >>> (data_width - 1));

    // Single register stage that only holds when the consumer stalls
    assign pair_in.ready = ref_out.ready || !ref_out.valid;

    always_ff @(posedge clock) begin
        if (!reset) begin
            ref_out.valid <= 1'b0;
        end else if (pair_in.ready) begin
            ref_out.valid <= pair_in.valid;
        end
    end

    always_ff @(posedge clock) begin
        if (pair_in.ready && pair_in.valid) begin
            ref_out.data <= id_term + iq_term;
            ref_out.dest <= pair_in.dest;
        end
    end

endmodule

/* hdl/quadrature_generator.sv */
`timescale 1ns/1ps

module quadrature_generator (
    input logic clock,
    input logic reset,
    input logic [reference_pkg::n_phases*reference_pkg::angle_width-1:0] phase_shifts,
    ref_stream_if.sink angle_in,
    ref_stream_if.source pair_out
);
    import reference_pkg::*;

    logic busy;
    logic accept;
    logic last_phase;
    logic [dest_width-1:0] phase_index;
    logic [angle_width-1:0] base_angle;
    logic [angle_width-1:0] shifted_angle;
    logic [sine_index_width-1:0] sine_index;
    logic [sine_index_width-1:0] cosine_index;
    quad_pair_t pair;

    assign angle_in.ready = !busy;
    assign accept = angle_in.valid && angle_in.ready;
    assign last_phase = phase_index == dest_width'(n_phases - 1);

    always_ff @(posedge clock) begin
        if (!reset) begin
            busy <= 1'b0;
            phase_index <= '0;
        end else if (accept) begin
            busy <= 1'b1;
            phase_index <= '0;
        end else if (busy && pair_out.ready) begin
            if (last_phase) begin
                busy <= 1'b0;
                phase_index <= '0;
            end else begin
                phase_index <= phase_index + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            base_angle <= angle_in.data;
        end
    end

    // Each phase sees the captured angle plus its own shift
    assign shifted_angle = base_angle + phase_shifts[phase_index*angle_width +: angle_width];
    assign sine_index = shifted_angle[angle_width-1 -: sine_index_width];

    // Cosine is sine a quarter of the table later, the index wraps by itself
    assign cosine_index = sine_index + sine_index_width'(sine_table_depth / 4);

    always_comb begin
        pair.sine = sine_lut[sine_index];
        pair.cosine = sine_lut[cosine_index];
    end

    assign pair_out.data = pair;
    assign pair_out.dest = phase_index;
    assign pair_out.valid = busy;

    // After an angle is taken the input stays blocked for exactly one pass over the phases
    assert property (@(posedge clock) disable iff (!reset)
        accept |=> !angle_in.ready [*n_phases] ##1 angle_in.ready);

endmodule

/* hdl/reference_controller.sv */
`timescale 1ns/1ps

module reference_controller (
    input  logic clock,
    input  logic reset,
    input  logic [reference_pkg::axil_addr_width-1:0] awaddr,
    input  logic awvalid,
    output logic awready,
    input  logic [reference_pkg::axil_data_width-1:0] wdata,
    input  logic wvalid,
    output logic wready,
    output logic bvalid,
    input  logic bready,
    input  logic [reference_pkg::axil_addr_width-1:0] araddr,
    input  logic arvalid,
    output logic arready,
    output logic [reference_pkg::axil_data_width-1:0] rdata,
    output logic rvalid,
    input  logic rready,
    input  logic [reference_pkg::angle_width-1:0] phase_data,
    input  logic phase_valid,
    output logic phase_ready,
    output logic angle_emulation,
    output logic [reference_pkg::angle_width-1:0] angle_out_data,
    output logic angle_out_valid,
    ref_stream_if.source angle_stream
);
    import reference_pkg::*;

    logic mode_reg;
    logic [axil_data_width-1:0] advance_reg;
    logic [axil_data_width-1:0] period_reg;
    logic [axil_data_width-1:0] read_value;
    logic write_accept;
    logic read_accept;
    logic [angle_width-1:0] emulated_data;
    logic emulated_valid;
    logic [angle_width-1:0] selected_data;
    logic selected_valid;

    // Address and data are taken together, one write in flight at a time
    assign write_accept = awvalid && wvalid && !bvalid;
    assign awready = write_accept;
    assign wready = write_accept;
    assign read_accept = arvalid && !rvalid;
    assign arready = read_accept;

    always_ff @(posedge clock) begin
        if (!reset) begin
            mode_reg <= 1'b0;
            advance_reg <= '0;
            period_reg <= '0;
            bvalid <= 1'b0;
        end else begin
            if (write_accept) begin
                bvalid <= 1'b1;
                case (awaddr[3:0])
                    reg_offset_mode: mode_reg <= wdata[0];
                    reg_offset_advance: advance_reg <= wdata;
                    reg_offset_period: period_reg <= wdata;
                    default: ;
                endcase
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_comb begin
        case (araddr[3:0])
            reg_offset_mode: read_value = {{(axil_data_width-1){1'b0}}, mode_reg};
            reg_offset_advance: read_value = advance_reg;
            reg_offset_period: read_value = period_reg;
            default: read_value = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            rvalid <= 1'b0;
        end else if (read_accept) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (read_accept) begin
            rdata <= read_value;
        end
    end

    // In emulation mode the external valid only triggers a sample of the accumulator
    angle_emulator emulator (
        .clock(clock),
        .reset(reset),
        .enable(mode_reg),
        .advance(advance_reg),
        .period(period_reg),
        .trigger(phase_valid && mode_reg),
        .angle_data(emulated_data),
        .angle_valid(emulated_valid)
    );

    assign selected_data = mode_reg ? emulated_data : phase_data;
    assign selected_valid = mode_reg ? emulated_valid : phase_valid;
    assign phase_ready = mode_reg ? 1'b1 : angle_stream.ready;

    assign angle_stream.data = selected_data;
    assign angle_stream.dest = '0;
    assign angle_stream.valid = selected_valid;

    assign angle_out_data = selected_data;
    assign angle_out_valid = selected_valid;
    assign angle_emulation = mode_reg;

    // A write response only ever follows an accepted write on the previous edge
    assert property (@(posedge clock) disable iff (!reset)
        $rose(bvalid) |-> $past(awvalid && awready && wvalid && wready));

endmodule

/* hdl/angle_emulator.sv */
`timescale 1ns/1ps

module angle_emulator (
    input  logic clock,
    input  logic reset,
    input  logic enable,
    input  logic [reference_pkg::axil_data_width-1:0] advance,
    input  logic [reference_pkg::axil_data_width-1:0] period,
    input  logic trigger,
    output logic [reference_pkg::angle_width-1:0] angle_data,
    output logic angle_valid
);
    import reference_pkg::*;

    logic [axil_data_width-1:0] period_count;
    logic [angle_width-1:0] accumulator;
    logic tick;

    // One tick every period+1 cycles
    assign tick = enable && (period_count == period);

    always_ff @(posedge clock) begin
        if (!reset) begin
            period_count <= '0;
        end else if (!enable || tick) begin
            period_count <= '0;
        end else begin
            period_count <= period_count + 1'b1;
        end
    end

    // Only the low half of advance matters, the angle wraps at 2^16
    always_ff @(posedge clock) begin
        if (!reset) begin
            accumulator <= '0;
        end else if (tick) begin
            accumulator <= accumulator + advance[angle_width-1:0];
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            angle_valid <= 1'b0;
        end else begin
            angle_valid <= trigger && enable;
        end
    end

    always_ff @(posedge clock) begin
        if (trigger) begin
            angle_data <= accumulator;
        end
    end

endmodule

/* hdl/ref_stream_if.sv */
`timescale 1ns/1ps

interface ref_stream_if #(
    parameter type payload_t = logic [reference_pkg::data_width-1:0]
);
    import reference_pkg::*;

    payload_t data;
    logic [dest_width-1:0] dest;
    logic valid;
    logic ready;

    // A beat moves when valid and ready are both high at the clock edge
    modport source (output data, output dest, output valid, input ready);

    modport sink (input data, input dest, input valid, output ready);

endinterface

/* hdl/reference_pkg.sv */
package reference_pkg;

    localparam int n_phases = 6;
    localparam int data_width = 16;
    localparam int angle_width = 16;
    localparam int dest_width = 3;

    // The top bits of the angle address a full-wave sine table
    localparam int sine_index_width = 8;
    localparam int sine_table_depth = 256;

    localparam int axil_addr_width = 32;
    localparam int axil_data_width = 32;

    localparam logic [3:0] reg_offset_mode = 4'h0;
    localparam logic [3:0] reg_offset_advance = 4'h4;
    localparam logic [3:0] reg_offset_period = 4'h8;

    typedef logic signed [data_width-1:0] sine_lut_t [sine_table_depth];

    typedef struct packed {
        logic signed [data_width-1:0] sine;
        logic signed [data_width-1:0] cosine;
    } quad_pair_t;

    // Entry k holds round(32767 * sin(2*pi*k/256)), cosine is read a quarter turn later
    function automatic sine_lut_t sine_table();
        sine_lut_t lut;
        real step;
        step = 2.0 * 3.14159265358979 / real'(sine_table_depth);
        for (int k = 0; k < sine_table_depth; k++) begin
            lut[k] = data_width'(int'(32767.0 * $sin(step * real'(k))));
        end
        return lut;
    endfunction

    localparam sine_lut_t sine_lut = sine_table();

endpackage
